// File: wh_link_pkg.sv
`default_nettype none

// link level view of the receive port
package wh_link_pkg;

  // one flit as it travels on the wormhole link
  localparam int flit_width_lp = 16;

  typedef logic [flit_width_lp-1:0] flit_t;

  // credits held by the upstream right after reset
  // the input buffer is sized to match, so a credit is a free slot
  localparam int link_credits_lp = 4;

endpackage

`default_nettype wire

// File: wh_packet_pkg.sv
`default_nettype none

// packet format carried over the link
package wh_packet_pkg;

  // length field, number of flits minus one, header flits included
  localparam int len_width_lp = 4;

  // destination nibble sits right above the length
  localparam int dest_width_lp = 4;

  // tag is the rest of the first flit plus the whole second flit
  localparam int tag_width_lp = 24;

  // header is always two flits long
  localparam int hdr_len_lp = 2;

  // finished headers waiting for the local consumer
  localparam int hdr_queue_els_lp = 2;

  // len in the low bits so it lines up with the low nibble of flit 0
  typedef struct packed {
    logic [tag_width_lp-1:0]  tag;
    logic [dest_width_lp-1:0] dest;
    logic [len_width_lp-1:0]  len;
  } hdr_t;

endpackage

`default_nettype wire

// File: wh_counter_set_down.sv
`timescale 1ns/1ps
`default_nettype none

module wh_counter_set_down (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic                                  set_i,
  input  logic [wh_packet_pkg::len_width_lp-1:0] val_i,
  input  logic                                  down_i,
  output logic [wh_packet_pkg::len_width_lp-1:0] count_r_o
);

  import wh_packet_pkg::*;

  logic [len_width_lp-1:0] count_r;

  // set and down together loads one less, so the first flit of a
  // packet is already counted in the cycle it is loaded
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_r <= '0;
    end else if (set_i && down_i) begin
      count_r <= val_i - len_width_lp'(1);
    end else if (set_i) begin
      count_r <= val_i;
    end else if (down_i) begin
      count_r <= count_r - len_width_lp'(1);
    end
  end

  assign count_r_o = count_r;

endmodule

`default_nettype wire

// File: wh_stream_control.sv
`timescale 1ns/1ps
`default_nettype none

module wh_stream_control (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic [wh_packet_pkg::len_width_lp-1:0] len_i,
  input  logic                                  link_accept_i,
  output logic                                  is_hdr_o,
  output logic                                  is_data_o,
  output logic                                  hdr_last_o
);

  import wh_packet_pkg::*;

  typedef enum logic {
    e_hdr,
    e_data
  } state_e;

  state_e state_r, state_n;

  logic is_hdr;
  logic is_data;

  // remaining flits, a count of one means the current flit is the last
  logic [len_width_lp-1:0] hdr_cnt;
  logic [len_width_lp-1:0] data_cnt;
  logic [len_width_lp-1:0] data_len;

  logic hdr_last;
  logic data_last;
  logic hdr_done;
  logic data_done;
  logic set_cnt;
  logic hdr_to_data;
  logic data_to_hdr;

  assign is_hdr  = (state_r == e_hdr);
  assign is_data = (state_r == e_data);

  // len counts flits minus one, add the one back and drop the header
  assign data_len = len_i - len_width_lp'(hdr_len_lp) + len_width_lp'(1);

  assign hdr_last  = (hdr_cnt == len_width_lp'(1));
  assign data_last = (data_cnt == len_width_lp'(1));
  assign hdr_done  = (hdr_cnt == '0);
  assign data_done = (data_cnt == '0);

  // first header flit of a packet, len_i is only valid here
  assign set_cnt = is_hdr & hdr_done & link_accept_i;

  wh_counter_set_down hdr_counter_i (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .set_i    (set_cnt),
    .val_i    (len_width_lp'(hdr_len_lp)),
    .down_i   (is_hdr & link_accept_i),
    .count_r_o(hdr_cnt)
  );

  // loaded alongside the header counter, only counts in the data state
  wh_counter_set_down data_counter_i (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .set_i    (set_cnt),
    .val_i    (data_len),
    .down_i   (is_data & link_accept_i),
    .count_r_o(data_cnt)
  );

  // data count was registered on the first header flit
  // a header-only packet stays in the header state
  assign hdr_to_data = link_accept_i & is_hdr & hdr_last & ~data_done;
  assign data_to_hdr = link_accept_i & is_data & data_last;

  always_comb begin
    case (state_r)
      e_hdr:   state_n = hdr_to_data ? e_data : e_hdr;
      e_data:  state_n = data_to_hdr ? e_hdr : e_data;
      default: state_n = e_hdr;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_hdr;
    end else begin
      state_r <= state_n;
    end
  end

  assign is_hdr_o   = is_hdr;
  assign is_data_o  = is_data;
  // push strobe for the assembler, qualified there by the shift
  assign hdr_last_o = is_hdr & hdr_last;

endmodule

`default_nettype wire

// File: wh_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module wh_fifo #(
  parameter type payload_t = logic,
  parameter int  els_p     = 4
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     v_i,
  input  payload_t data_i,
  output logic     ready_o,
  output logic     v_o,
  output payload_t data_o,
  input  logic     yumi_i
);

  payload_t mem_r [els_p];

  logic [$clog2(els_p)-1:0] wr_ptr_r;
  logic [$clog2(els_p)-1:0] rd_ptr_r;
  logic [$clog2(els_p+1)-1:0] count_r;

  logic full;
  logic enq;
  logic deq;

  assign full = (count_r == $bits(count_r)'(els_p));
  assign v_o  = (count_r != '0);

  // head is read straight from storage, no output register
  assign data_o = mem_r[rd_ptr_r];

  assign deq = v_o & yumi_i;
  // a full buffer still takes a new entry when the head leaves
  assign ready_o = ~full | deq;
  assign enq     = v_i & ready_o;

  // new entry lands in the tail slot
  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
    end else begin
      // wrap explicitly, depth need not be a power of two
      if (enq) begin
        wr_ptr_r <= (wr_ptr_r == $bits(wr_ptr_r)'(els_p - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (deq) begin
        rd_ptr_r <= (rd_ptr_r == $bits(rd_ptr_r)'(els_p - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_r <= '0;
    end else begin
      case ({enq, deq})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: wh_hdr_assembler.sv
`timescale 1ns/1ps
`default_nettype none

module wh_hdr_assembler (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  wh_link_pkg::flit_t   flit_i,
  input  logic                 shift_i,
  input  logic                 last_i,
  output logic                 hdr_ready_o,
  output logic                 hdr_v_o,
  output wh_packet_pkg::hdr_t  hdr_o,
  input  logic                 queue_ready_i
);

  import wh_link_pkg::*;
  import wh_packet_pkg::*;

  // first header flit waits here until the second one shows up
  flit_t flit_r;
  logic  held_v_r;

  always_ff @(posedge clk_i) begin
    if (shift_i && !last_i) begin
      flit_r <= flit_i;
    end
  end

  // tracks whether flit_r holds the front half of a header
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      held_v_r <= 1'b0;
    end else if (shift_i) begin
      held_v_r <= ~last_i;
    end
  end

  // nothing finished is kept here, so back-pressure comes from the queue
  assign hdr_ready_o = queue_ready_i;

  // header goes into the queue in the same cycle its last flit arrives
  assign hdr_v_o = shift_i & last_i & held_v_r;

  // len and dest from the low byte of flit 0
  assign hdr_o.len  = flit_r[len_width_lp-1:0];
  assign hdr_o.dest = flit_r[len_width_lp+:dest_width_lp];
  // tag is the upper byte of flit 0 followed by all of flit 1
  assign hdr_o.tag  = {flit_r[flit_width_lp-1:len_width_lp+dest_width_lp], flit_i};

endmodule

`default_nettype wire

// File: wh_stream_splitter.sv
`timescale 1ns/1ps
`default_nettype none

module wh_stream_splitter (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                link_v_i,
  input  wh_link_pkg::flit_t  link_data_i,
  output logic                link_credit_o,
  output logic                hdr_v_o,
  output wh_packet_pkg::hdr_t hdr_o,
  input  logic                hdr_ready_i,
  output logic                data_v_o,
  output wh_link_pkg::flit_t  data_o,
  input  logic                data_ready_i
);

  import wh_link_pkg::*;
  import wh_packet_pkg::*;

  // head of the input buffer
  logic  in_v;
  flit_t in_flit;
  logic  in_ready;
  logic  link_push;

  logic is_hdr;
  logic is_data;
  logic hdr_last;
  logic link_accept;

  // assembler to header queue
  logic asm_ready;
  logic asm_hdr_v;
  hdr_t asm_hdr;
  logic hq_ready;

  // the upstream only sends against a credit, so the buffer always has room
  assign link_push = link_v_i & in_ready;

  wh_fifo #(
    .payload_t(flit_t),
    .els_p    (link_credits_lp)
  ) in_fifo_i (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .v_i    (link_push),
    .data_i (link_data_i),
    .ready_o(in_ready),
    .v_o    (in_v),
    .data_o (in_flit),
    .yumi_i (link_accept)
  );

  wh_stream_control stream_control_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .len_i        (in_flit[len_width_lp-1:0]),
    .link_accept_i(link_accept),
    .is_hdr_o     (is_hdr),
    .is_data_o    (is_data),
    .hdr_last_o   (hdr_last)
  );

  // head leaves when whichever side it is steered to can take it
  assign link_accept = in_v & ((is_hdr & asm_ready) | (is_data & data_ready_i));

  // one credit back per flit removed from the buffer
  assign link_credit_o = link_accept;

  // data flits go straight out from the buffer head
  assign data_v_o = in_v & is_data;
  assign data_o   = in_flit;

  wh_hdr_assembler hdr_assembler_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .flit_i       (in_flit),
    .shift_i      (link_accept & is_hdr),
    .last_i       (hdr_last),
    .hdr_ready_o  (asm_ready),
    .hdr_v_o      (asm_hdr_v),
    .hdr_o        (asm_hdr),
    .queue_ready_i(hq_ready)
  );

  wh_fifo #(
    .payload_t(hdr_t),
    .els_p    (hdr_queue_els_lp)
  ) hdr_queue_i (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .v_i    (asm_hdr_v),
    .data_i (asm_hdr),
    .ready_o(hq_ready),
    .v_o    (hdr_v_o),
    .data_o (hdr_o),
    .yumi_i (hdr_v_o & hdr_ready_i)
  );

endmodule

`default_nettype wire

// File: wh_stream_splitter_assert.sv
`timescale 1ns/1ps
`default_nettype none

module wh_stream_splitter_assert (
  input logic                clk_i,
  input logic                reset_i,
  input logic                link_v_i,
  input logic                link_credit_i,
  input logic                hdr_v_i,
  input wh_packet_pkg::hdr_t hdr_i,
  input logic                hdr_ready_i,
  input logic                data_v_i,
  input wh_link_pkg::flit_t  data_i,
  input logic                data_ready_i
);

  import wh_link_pkg::*;

  // flits sent upstream and not yet credited back
  int outstanding_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      outstanding_r <= 0;
    end else begin
      outstanding_r <= outstanding_r + int'(link_v_i) - int'(link_credit_i);
    end
  end

  // in flight count stays between zero and what the buffer holds
  // a credit for a flit never sent drives it below zero
  credit_limit_a: assert property (@(posedge clk_i) disable iff (reset_i)
    outstanding_r >= 0 && outstanding_r <= link_credits_lp)
    else $error("flits in flight outside the range of link credits");

  // state was reset on the previous edge, so everything is quiet
  reset_quiet_a: assert property (@(posedge clk_i)
    $past(reset_i) |-> !hdr_v_i && !data_v_i && !link_credit_i)
    else $error("output active during or right after reset");

  // stalled header must not change under the consumer
  hdr_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    hdr_v_i && !hdr_ready_i |=> hdr_v_i && $stable(hdr_i))
    else $error("header changed while stalled");

  data_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    data_v_i && !data_ready_i |=> data_v_i && $stable(data_i))
    else $error("data flit changed while stalled");

endmodule

bind wh_stream_splitter wh_stream_splitter_assert wh_stream_splitter_assert_i (
  .clk_i        (clk_i),
  .reset_i      (reset_i),
  .link_v_i     (link_v_i),
  .link_credit_i(link_credit_o),
  .hdr_v_i      (hdr_v_o),
  .hdr_i        (hdr_o),
  .hdr_ready_i  (hdr_ready_i),
  .data_v_i     (data_v_o),
  .data_i       (data_o),
  .data_ready_i (data_ready_i)
);

`default_nettype wire

// File: tb_wh_stream_splitter.sv
`timescale 1ns/1ps
`default_nettype none

module tb_wh_stream_splitter;

  import wh_link_pkg::*;
  import wh_packet_pkg::*;

  localparam int reset_cycles_lp = 4;
  localparam int num_pkts_lp     = 12;
  // percent of cycles with a ready high, and with a free credit spent
  localparam int ready_pct_lp    = 70;
  localparam int send_pct_lp     = 75;
  // idle cycles at the end to catch stray outputs
  localparam int drain_cycles_lp = 8;

  // one packet of the stimulus table
  typedef struct packed {
    logic [dest_width_lp-1:0] dest;
    logic [tag_width_lp-1:0]  tag;
    logic [len_width_lp-1:0]  len;
  } pkt_row_t;

  logic  clk_i = 1'b0;
  logic  reset_i;
  logic  link_v_i;
  flit_t link_data_i;
  logic  link_credit_o;
  logic  hdr_v_o;
  hdr_t  hdr_o;
  logic  hdr_ready_i;
  logic  data_v_o;
  flit_t data_o;
  logic  data_ready_i;

  pkt_row_t pkt_table [num_pkts_lp];

  // flits still to send, and what each output should give, in order
  flit_t link_q[$];
  hdr_t  exp_hdr_q[$];
  flit_t exp_data_q[$];

  // credits the upstream model holds right now
  int credits     = 0;
  int cycle_count = 0;
  int cycle_limit = 0;

  wh_stream_splitter wh_stream_splitter_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .link_v_i     (link_v_i),
    .link_data_i  (link_data_i),
    .link_credit_o(link_credit_o),
    .hdr_v_o      (hdr_v_o),
    .hdr_o        (hdr_o),
    .hdr_ready_i  (hdr_ready_i),
    .data_v_o     (data_v_o),
    .data_o       (data_o),
    .data_ready_i (data_ready_i)
  );

  always #2 clk_i = ~clk_i;

  task automatic stop_run();
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    stop_run();
  endtask

  task automatic check_hdr(input string name, input hdr_t expected, input hdr_t actual);
    if (actual !== expected) begin
      $display("** Error: %s expected %h got %h", name, expected, actual);
      stop_run();
    end
  endtask

  task automatic check_flit(input string name, input flit_t expected, input flit_t actual);
    if (actual !== expected) begin
      $display("** Error: %s expected %h got %h", name, expected, actual);
      stop_run();
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("** Error: %s expected %h got %h", name, expected, actual);
      stop_run();
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
      $display("** Error: %s expected %h got %h", name, expected, actual);
      stop_run();
    end
  endtask

  // dest, tag, len
  // header-only runs (len 1) sit between the long packets
  task automatic load_table();
    pkt_table[0]  = '{4'h3, 24'h5a1c0e, 4'h4};
    pkt_table[1]  = '{4'h7, 24'h00beef, 4'h1};
    pkt_table[2]  = '{4'h1, 24'h123456, 4'h1};
    pkt_table[3]  = '{4'h2, 24'habcdef, 4'h1};
    pkt_table[4]  = '{4'he, 24'h0f0f0f, 4'hf};
    pkt_table[5]  = '{4'h9, 24'hc0ffee, 4'h2};
    pkt_table[6]  = '{4'h4, 24'h765432, 4'h1};
    pkt_table[7]  = '{4'h5, 24'h111111, 4'h9};
    pkt_table[8]  = '{4'ha, 24'hfedcba, 4'h1};
    pkt_table[9]  = '{4'hb, 24'h808080, 4'h1};
    pkt_table[10] = '{4'hc, 24'h246813, 4'hc};
    pkt_table[11] = '{4'h6, 24'h13579b, 4'h3};
  endtask

  // turn each row into link flits and the outputs it should produce
  task automatic build_stream();
    pkt_row_t row;
    hdr_t     exp_hdr;
    flit_t    data_seq;
    int       n_data;
    int       p;
    int       d;
    data_seq = 16'h0100;
    for (p = 0; p < num_pkts_lp; p++) begin
      row = pkt_table[p];
      // flit 0 is tag top byte, dest, len; flit 1 is the low tag bits
      link_q.push_back({row.tag[23:16], row.dest, row.len});
      link_q.push_back(row.tag[15:0]);
      exp_hdr.tag  = row.tag;
      exp_hdr.dest = row.dest;
      exp_hdr.len  = row.len;
      exp_hdr_q.push_back(exp_hdr);
      // len is flits minus one, header flits included
      n_data = int'(row.len) + 1 - hdr_len_lp;
      for (d = 0; d < n_data; d++) begin
        link_q.push_back(data_seq);
        exp_data_q.push_back(data_seq);
        data_seq = data_seq + 16'h1;
      end
    end
  endtask

  // upstream model and random ready, driven just after the edge
  task automatic drive_cycle();
    @(posedge clk_i);
    #1;
    hdr_ready_i  = ($urandom % 100) < ready_pct_lp;
    data_ready_i = ($urandom % 100) < ready_pct_lp;
    if (link_q.size() != 0 && credits > 0 && ($urandom % 100) < send_pct_lp) begin
      link_v_i    = 1'b1;
      link_data_i = link_q.pop_front();
      credits     = credits - 1;
    end else begin
      link_v_i    = 1'b0;
      link_data_i = '0;
    end
  endtask

  // outputs are settled mid cycle, handshakes complete at the next edge
  task automatic watch_outputs();
    @(negedge clk_i);
    if (link_credit_o) begin
      credits = credits + 1;
      if (credits > link_credits_lp) begin
        report_failure("a credit came back for a flit that was never sent");
      end
    end
    if (hdr_v_o && hdr_ready_i) begin
      if (exp_hdr_q.size() == 0) begin
        report_failure("a header came out when none was left to expect");
      end else begin
        check_hdr("hdr_o", exp_hdr_q.pop_front(), hdr_o);
      end
    end
    if (data_v_o && data_ready_i) begin
      if (exp_data_q.size() == 0) begin
        report_failure("a data flit came out when none was left to expect");
      end else begin
        check_flit("data_o", exp_data_q.pop_front(), data_o);
      end
    end
  endtask

  task automatic check_quiet();
    check_bit("hdr_v_o", 1'b0, hdr_v_o);
    check_bit("data_v_o", 1'b0, data_v_o);
    check_bit("link_credit_o", 1'b0, link_credit_o);
  endtask

  // run limit, scaled from the number of flits in the table
  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      report_failure("run timed out before every packet came out");
    end
  end

  initial begin
    void'($urandom(32'hc89c));
    reset_i      = 1'b1;
    link_v_i     = 1'b0;
    link_data_i  = '0;
    hdr_ready_i  = 1'b0;
    data_ready_i = 1'b0;
    credits      = link_credits_lp;
    load_table();
    build_stream();
    cycle_limit = 20 * link_q.size() + 100;

    // outputs stay low through reset and the first cycle after it
    repeat (reset_cycles_lp - 1) begin
      @(posedge clk_i);
      @(negedge clk_i);
      check_quiet();
    end
    @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    @(negedge clk_i);
    check_quiet();

    while (exp_hdr_q.size() != 0 || exp_data_q.size() != 0) begin
      drive_cycle();
      watch_outputs();
    end

    // nothing more may come out, and every credit is home
    repeat (drain_cycles_lp) begin
      drive_cycle();
      watch_outputs();
    end
    check_count("upstream credits", link_credits_lp, credits);

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: wh_stream.f
wh_link_pkg.sv
wh_packet_pkg.sv
wh_counter_set_down.sv
wh_stream_control.sv
wh_fifo.sv
wh_hdr_assembler.sv
wh_stream_splitter.sv
wh_stream_splitter_assert.sv
tb_wh_stream_splitter.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the splitter testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
  --top-module tb_wh_stream_splitter \
  -f wh_stream.f

# a failing run exits nonzero, so capture first and judge by the output
sim_out=$(./obj_dir/Vtb_wh_stream_splitter 2>&1) || true
echo "$sim_out"

if grep -qx "ALL TESTS PASSED" <<< "$sim_out"; then
  exit 0
fi
exit 1
